/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_bringup
FILELIST = src.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* bringup_params.svh */
// bring-up monitor constants for pin count, default timing, line characters and shifter direction
`ifndef BRINGUP_PARAMS_SVH
`define BRINGUP_PARAMS_SVH

// pin bank
`define BU_NUM_PINS         8

// timing defaults at 12 MHz
`define BU_CLOCKS_PER_BAUD  104      // 115200 baud
`define BU_WINDOW_CLOCKS    12000    // 1 ms decay window
`define BU_SCAN_CLOCKS      1200000  // 10 lines per second
`define BU_DRIVE_CLOCKS     6000     // 1 kHz square wave on the driver pin

// characters of one report line
`define BU_CHAR_LOW         8'h30    // '0'
`define BU_CHAR_HIGH        8'h31    // '1'
`define BU_CHAR_TOGGLE      8'h54    // 'T'
`define BU_CHAR_EOL         8'h0A    // line feed

// shifter direction level that makes the board side an input
`define BU_LVL_DIR_INPUT    1'b1

`endif

/* bringup_pkg.sv */
// bring-up monitor types for pin activity classes and the scanner FSM
package bringup_pkg;

	// activity seen on one pin over a decay window
	typedef enum logic [1:0] {
		PIN_LOW      = 2'd0,  // only low, or nothing seen yet
		PIN_HIGH     = 2'd1,  // only high
		PIN_TOGGLING = 2'd2   // both levels within the window
	} pin_class_e;

	// line scanner FSM
	typedef enum logic [1:0] {
		SCAN_IDLE = 2'd0,  // waiting for a scan strobe
		SCAN_SEND = 2'd1,  // waiting for the uart to go idle
		SCAN_WAIT = 2'd2   // one cycle until busy reflects the write
	} scan_state_e;

endpackage

/* bringup_timebase.sv */
// bring-up timebase producing the window strobe, the scan strobe and the driver square wave
`timescale 1ns/100ps
`include "bringup_params.svh"

module bringup_timebase #(
	parameter int WINDOW_CLOCKS = `BU_WINDOW_CLOCKS,
	parameter int SCAN_CLOCKS   = `BU_SCAN_CLOCKS,
	parameter int DRIVE_CLOCKS  = `BU_DRIVE_CLOCKS
) (
	input  logic clock,
	input  logic rst_n_i,
	output logic window_o,  // one cycle per decay window
	output logic scan_o,    // one cycle per scan period
	output logic drive_o    // test driver pin
);

	localparam int NUM_DIV   = 3;
	localparam int DIV_WIN   = 0;
	localparam int DIV_SCAN  = 1;
	localparam int DIV_DRIVE = 2;
	localparam int PERIODS [NUM_DIV] = '{WINDOW_CLOCKS, SCAN_CLOCKS, DRIVE_CLOCKS};

	logic [NUM_DIV-1:0] tick;

	// one free-running divider per period
	for (genvar g = 0; g < NUM_DIV; g++) begin : g_div
		localparam int CNT_W = $clog2(PERIODS[g] + 1);
		localparam logic [CNT_W-1:0] LAST = CNT_W'(PERIODS[g] - 1);

		logic [CNT_W-1:0] cnt;
		logic             tick_q;

		always_ff @(posedge clock or negedge rst_n_i) begin
			if (!rst_n_i) begin
				cnt <= '0;
				tick_q <= 1'b0;
			end else if (cnt == LAST) begin
				cnt <= '0;
				tick_q <= 1'b1;  // first tick a full period after reset
			end else begin
				cnt <= cnt + 1'b1;
				tick_q <= 1'b0;
			end
		end

		assign tick[g] = tick_q;
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i)
			drive_o <= 1'b0;
		else if (tick[DIV_DRIVE])
			drive_o <= ~drive_o;  // half period per tick
	end

	assign window_o = tick[DIV_WIN];
	assign scan_o = tick[DIV_SCAN];

endmodule

/* bringup_top.sv */
// level-shifter bring-up monitor top, reports pin activity as one text line per scan
`timescale 1ns/100ps
`include "bringup_params.svh"

module bringup_top import bringup_pkg::*; #(
	parameter int CLOCKS_PER_BAUD = `BU_CLOCKS_PER_BAUD,
	parameter int WINDOW_CLOCKS   = `BU_WINDOW_CLOCKS,
	parameter int SCAN_CLOCKS     = `BU_SCAN_CLOCKS,
	parameter int DRIVE_CLOCKS    = `BU_DRIVE_CLOCKS
) (
	input  logic                    clock,
	input  logic                    rst_n_i,
	input  logic [`BU_NUM_PINS-1:0] pins_i,      // monitored shifter outputs
	output logic                    drive_o,     // square wave test driver
	output logic                    uart_tx_o,
	output logic [3:0]              lvl_dir_o,   // one per shifter bank
	output logic                    lvl_oe_n_o
);

	logic       window;
	logic       scan;
	logic       uart_write;
	logic [7:0] uart_data;
	logic       uart_busy;
	pin_class_e pin_class [`BU_NUM_PINS];

	bringup_timebase #(
		.WINDOW_CLOCKS(WINDOW_CLOCKS),
		.SCAN_CLOCKS(SCAN_CLOCKS),
		.DRIVE_CLOCKS(DRIVE_CLOCKS)
	) i_timebase (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.window_o(window),
		.scan_o(scan),
		.drive_o(drive_o)
	);

	for (genvar i = 0; i < `BU_NUM_PINS; i++) begin : g_sensor
		pin_sensor i_sensor (
			.clock(clock),
			.rst_n_i(rst_n_i),
			.pin_i(pins_i[i]),
			.window_i(window),
			.class_o(pin_class[i])
		);
	end

	pin_scanner #(
		.NUM_PINS(`BU_NUM_PINS)
	) i_scanner (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.scan_i(scan),
		.class_i(pin_class),
		.busy_i(uart_busy),
		.write_o(uart_write),
		.data_o(uart_data)
	);

	uart_tx #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
	) i_uart (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.write_i(uart_write),
		.data_i(uart_data),
		.busy_o(uart_busy),
		.tx_o(uart_tx_o)
	);

	// every shifter bank faces the board as an input
	assign lvl_dir_o = {4{`BU_LVL_DIR_INPUT}};
	assign lvl_oe_n_o = 1'b0;  // outputs enabled

endmodule

/* pin_scanner.sv */
// line scanner, snapshots every pin class and feeds one character per pin to the uart
`timescale 1ns/100ps
`include "bringup_params.svh"

module pin_scanner import bringup_pkg::*; #(
	parameter int NUM_PINS = `BU_NUM_PINS
) (
	input  logic       clock,
	input  logic       rst_n_i,
	input  logic       scan_i,              // periodic scan strobe
	input  pin_class_e class_i [NUM_PINS],  // live classes from the sensors
	input  logic       busy_i,              // uart still shifting
	output logic       write_o,
	output logic [7:0] data_o
);

	localparam int IDX_W = $clog2(NUM_PINS + 1);
	localparam int PIN_W = (NUM_PINS > 1) ? $clog2(NUM_PINS) : 1;
	localparam logic [IDX_W-1:0] EOL_IDX = IDX_W'(NUM_PINS);

	scan_state_e      state;
	logic [IDX_W-1:0] idx;        // character position in the line
	pin_class_e       snap [NUM_PINS];
	logic [7:0]       next_char;
	logic             start;
	logic             send;

	assign start = (state == SCAN_IDLE) && scan_i;
	assign send = (state == SCAN_SEND) && !busy_i;

	// class to character, line feed after the last pin
	always_comb begin
		next_char = `BU_CHAR_EOL;
		if (idx != EOL_IDX) begin
			case (snap[idx[PIN_W-1:0]])
				PIN_HIGH:     next_char = `BU_CHAR_HIGH;
				PIN_TOGGLING: next_char = `BU_CHAR_TOGGLE;
				default:      next_char = `BU_CHAR_LOW;
			endcase
		end
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= SCAN_IDLE;
			idx <= '0;
			write_o <= 1'b0;
		end else begin
			write_o <= 1'b0;  // single-cycle write strobe
			case (state)
				SCAN_IDLE: begin
					idx <= '0;
					if (start)
						state <= SCAN_SEND;
				end
				SCAN_SEND: begin
					if (send) begin
						write_o <= 1'b1;
						state <= SCAN_WAIT;
					end
				end
				SCAN_WAIT: begin
					// busy from the uart shows up one cycle after the write
					if (idx == EOL_IDX) begin
						state <= SCAN_IDLE;
					end else begin
						idx <= idx + 1'b1;
						state <= SCAN_SEND;
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			snap <= class_i;  // whole line from one instant
		if (send)
			data_o <= next_char;
	end

endmodule

/* pin_sensor.sv */
// pin activity sensor, synchronizes one pin and classifies it once per decay window
`timescale 1ns/100ps

module pin_sensor import bringup_pkg::*; (
	input  logic       clock,
	input  logic       rst_n_i,
	input  logic       pin_i,     // asynchronous board pin
	input  logic       window_i,  // end of decay window
	output pin_class_e class_o
);

	logic [1:0] sync_q;
	logic       pin_s;
	logic       seen_high;
	logic       seen_low;
	logic       any_high;
	logic       any_low;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i)
			sync_q <= 2'b00;
		else
			sync_q <= {sync_q[0], pin_i};  // 2-flop synchronizer
	end

	assign pin_s = sync_q[1];

	// include the current sample so the strobe cycle is not lost
	assign any_high = seen_high | pin_s;
	assign any_low = seen_low | ~pin_s;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			seen_high <= 1'b0;
			seen_low <= 1'b0;
			class_o <= PIN_LOW;
		end else if (window_i) begin
			seen_high <= 1'b0;  // start a fresh window
			seen_low <= 1'b0;
			if (any_high && any_low)
				class_o <= PIN_TOGGLING;
			else if (any_high)
				class_o <= PIN_HIGH;
			else
				class_o <= PIN_LOW;
		end else begin
			seen_high <= any_high;
			seen_low <= any_low;
		end
	end

endmodule

/* src.f */
+incdir+.
bringup_pkg.sv
bringup_timebase.sv
pin_sensor.sv
pin_scanner.sv
uart_tx.sv
bringup_top.sv
tb_bringup.sv

/* tb_bringup.sv */
// testbench for the bring-up monitor that decodes the uart report lines and checks them per pin
`timescale 1ns/100ps
`include "bringup_params.svh"

module tb_bringup;

	localparam int CLK_PERIOD      = 100;
	localparam int CLOCKS_PER_BAUD = 4;
	localparam int WINDOW_CLOCKS   = 64;
	localparam int SCAN_CLOCKS     = 512;
	localparam int DRIVE_CLOCKS    = 8;
	localparam int NP              = `BU_NUM_PINS;
	localparam int LINE_CHARS      = NP + 1;       // one per pin plus line feed
	localparam int NUM_SCEN        = 7;
	localparam int START_LIMIT     = 2 * SCAN_CLOCKS;
	localparam int WATCHDOG_NS     = (NUM_SCEN + 1) * 3 * SCAN_CLOCKS * CLK_PERIOD
		+ 10 * SCAN_CLOCKS * CLK_PERIOD;

	logic          clock;
	logic          rst_n_i;
	logic [NP-1:0] pins_i = '0;
	logic          drive_o;
	logic          uart_tx_o;
	logic [3:0]    lvl_dir_o;
	logic          lvl_oe_n_o;

	logic [NP-1:0] static_pat;   // levels of the static pins
	logic [NP-1:0] toggle_mask;  // pins looped back from drive_o
	logic [7:0]    line_buf [LINE_CHARS];
	logic          lost_sync;
	int            mismatch_count;
	int            failure_count;
	int            seed;
	logic          drive_prev;
	logic          drive_synced;
	int            drive_run;

	bringup_top #(
		.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD),
		.WINDOW_CLOCKS(WINDOW_CLOCKS),
		.SCAN_CLOCKS(SCAN_CLOCKS),
		.DRIVE_CLOCKS(DRIVE_CLOCKS)
	) i_dut (
		.clock(clock),
		.rst_n_i(rst_n_i),
		.pins_i(pins_i),
		.drive_o(drive_o),
		.uart_tx_o(uart_tx_o),
		.lvl_dir_o(lvl_dir_o),
		.lvl_oe_n_o(lvl_oe_n_o)
	);

	initial clock = 1'b0;
	always #(CLK_PERIOD / 2) clock = ~clock;

	task automatic report_mismatch(input string name, input int expected, input int actual);
		mismatch_count++;
		$display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	// toggling pins follow the driver pin and the rest hold their level
	always @(negedge clock)
		pins_i <= (static_pat & ~toggle_mask) | ({NP{drive_o}} & toggle_mask);

	// shifter control is constant for the whole run
	assert property (@(posedge clock) lvl_dir_o == {4{`BU_LVL_DIR_INPUT}})
		else report_mismatch("lvl_dir_o", int'({4{`BU_LVL_DIR_INPUT}}), int'(lvl_dir_o));
	assert property (@(posedge clock) lvl_oe_n_o == 1'b0)
		else report_mismatch("lvl_oe_n_o", 0, int'(lvl_oe_n_o));

	// driver half period counted on falling edges
	always @(negedge clock) begin
		if (!rst_n_i) begin
			drive_prev = 1'b0;
			drive_synced = 1'b0;
			drive_run = 0;
		end else if (drive_o !== drive_prev) begin
			if (drive_synced)
				assert (drive_run == DRIVE_CLOCKS)
					else report_mismatch("drive_o half period", DRIVE_CLOCKS, drive_run);
			drive_synced = 1'b1;  // first edge only starts the count
			drive_prev = drive_o;
			drive_run = 1;
		end else begin
			drive_run++;
		end
	end

	// one 8N1 frame sampled on falling clock edges near mid-bit
	task automatic decode_char(output logic [7:0] data, output logic ok);
		int wait_cnt;
		int b;
		wait_cnt = 0;
		ok = 1'b0;
		data = '0;
		@(negedge clock);
		while (uart_tx_o !== 1'b0 && wait_cnt < START_LIMIT) begin
			@(negedge clock);
			wait_cnt++;
		end
		if (uart_tx_o !== 1'b0) begin
			failure_count++;
			$display("no start bit on uart_tx_o within %0d clocks at %0t ns", START_LIMIT, $time);
		end else begin
			repeat (CLOCKS_PER_BAUD / 2 - 1) @(negedge clock);
			assert (uart_tx_o === 1'b0)
				else report_mismatch("uart_tx_o start bit", 0, int'(uart_tx_o));
			for (b = 0; b < 8; b++) begin
				repeat (CLOCKS_PER_BAUD) @(negedge clock);
				data[b] = uart_tx_o;  // lsb first
			end
			repeat (CLOCKS_PER_BAUD) @(negedge clock);
			assert (uart_tx_o === 1'b1)
				else report_mismatch("uart_tx_o stop bit", 1, int'(uart_tx_o));
			ok = 1'b1;
		end
	endtask

	// collects characters up to the line feed
	task automatic receive_line(output int n_chars);
		logic [7:0] ch;
		logic       ok;
		n_chars = 0;
		ch = 8'h00;
		while (ch != `BU_CHAR_EOL && n_chars < LINE_CHARS && !lost_sync) begin
			decode_char(ch, ok);
			if (!ok) begin
				lost_sync = 1'b1;
			end else begin
				line_buf[n_chars] = ch;
				n_chars++;
			end
		end
		if (!lost_sync) begin
			assert (n_chars == LINE_CHARS) else report_mismatch("line length", LINE_CHARS, n_chars);
			assert (ch == `BU_CHAR_EOL) else report_mismatch("line end", `BU_CHAR_EOL, int'(ch));
		end
	endtask

	task automatic check_line(input logic [NP-1:0] levels, input logic [NP-1:0] toggles);
		logic [7:0] expected;
		int         n;
		int         i;
		receive_line(n);
		if (!lost_sync && n == LINE_CHARS) begin
			for (i = 0; i < NP; i++) begin
				if (toggles[i])
					expected = `BU_CHAR_TOGGLE;
				else if (levels[i])
					expected = `BU_CHAR_HIGH;
				else
					expected = `BU_CHAR_LOW;
				assert (line_buf[i] == expected)
					else report_mismatch($sformatf("uart char of pin %0d", i),
						int'(expected), int'(line_buf[i]));
			end
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, report lines stopped", WATCHDOG_NS);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0]   rnd;
		logic [NP-1:0] levels;
		logic [NP-1:0] toggles;
		int            n;
		int            s;
		seed = 50210;
		mismatch_count = 0;
		failure_count = 0;
		lost_sync = 1'b0;
		static_pat = '0;
		toggle_mask = '0;
		rst_n_i = 1'b0;
		repeat (4) @(posedge clock);
		@(negedge clock);
		// idle levels of the serial line and the driver pin out of reset
		assert (uart_tx_o === 1'b1) else report_mismatch("uart_tx_o", 1, int'(uart_tx_o));
		assert (drive_o === 1'b0) else report_mismatch("drive_o", 0, int'(drive_o));
		rst_n_i = 1'b1;
		check_line('0, '0);  // pins low since reset
		for (s = 0; s < NUM_SCEN && !lost_sync; s++) begin
			rnd = $random(seed);
			levels = rnd[NP-1:0];
			toggles = '0;
			case (s)
				0: levels = '0;
				4: toggles = 8'hA5;
				5: begin
					rnd = $random(seed);
					toggles = rnd[NP-1:0];
				end
				6: begin
					levels = '1;
					toggles = 8'h3C;
				end
				default: toggles = '0;
			endcase
			static_pat = levels;  // still on the falling edge of the stop bit sample
			toggle_mask = toggles;
			receive_line(n);      // snapshot may straddle the change
			check_line(levels, toggles);
		end
		if (lost_sync)
			$display("report lines stopped before all scenarios ran");
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0 && !lost_sync) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* uart_tx.sv */
// 8N1 uart transmitter with a write strobe and busy flag
`timescale 1ns/100ps
`include "bringup_params.svh"

module uart_tx #(
	parameter int CLOCKS_PER_BAUD = `BU_CLOCKS_PER_BAUD
) (
	input  logic       clock,
	input  logic       rst_n_i,
	input  logic       write_i,  // taken only while not busy
	input  logic [7:0] data_i,
	output logic       busy_o,
	output logic       tx_o      // serial line, idles high
);

	localparam int BAUD_W = $clog2(CLOCKS_PER_BAUD + 1);
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(CLOCKS_PER_BAUD - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;  // start, 8 data, stop

	logic [BAUD_W-1:0] baud_cnt;
	logic [3:0]        bit_cnt;
	logic [8:0]        shreg;     // data bits then stop bit
	logic              accept;
	logic              bit_end;

	assign accept = write_i && !busy_o;
	assign bit_end = busy_o && (baud_cnt == BAUD_LAST);

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_o <= 1'b0;
			tx_o <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (accept) begin
			busy_o <= 1'b1;
			tx_o <= 1'b0;  // start bit
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (bit_end) begin
			baud_cnt <= '0;
			if (bit_cnt == STOP_BIT) begin
				busy_o <= 1'b0;  // stop bit fully sent
			end else begin
				tx_o <= shreg[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else if (busy_o) begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			shreg <= {1'b1, data_i};
		else if (bit_end)
			shreg <= {1'b1, shreg[8:1]};  // lsb first
	end

endmodule
